// ==== Makefile ====
# Verilator build and run for the matrix inverse testbench

VERILATOR ?= verilator
TOP       ?= tb_matrix_inverse
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
EXTRA     ?=

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
src/mat_pkg.sv
src/row_alu.sv
src/matrix_store.sv
src/inverse_ctrl.sv
src/matrix_inverse.sv
tb/matrix_inverse_props.sv
tb/tb_matrix_inverse.sv

// ==== src/inverse_ctrl.sv ====
`default_nettype none

module inverse_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  mat_pkg::mat_row_t col_elems,
	output mat_pkg::row_cmd_t cmd,
	output logic              busy,
	output logic              done,
	output logic              singular
);
	import mat_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		SEARCH,
		SWAP,
		ELIM,
		NORM,
		FINISH
	} state_t;

	state_t   state;
	row_idx_t col_k;    // current pivot column
	row_idx_t row_q;    // swap row or target row
	logic     found;
	row_idx_t piv_sel;
	row_idx_t first_elim;
	row_idx_t elim_next;
	logic     elim_last;

	//////////////////////////////////////////////////////////////////////
	// pivot search and row stepping
	//////////////////////////////////////////////////////////////////////

	// first nonzero at or below the diagonal
	always_comb
	begin
		found   = 1'b0;
		piv_sel = col_k;
		for (int i = MAT_N - 1; i >= 0; i--)
		begin
			if (row_idx_t'(i) >= col_k && col_elems[i] != '0)
			begin
				found   = 1'b1;
				piv_sel = row_idx_t'(i);
			end
		end
	end

	assign first_elim = (col_k == '0) ? row_idx_t'(1) : '0;
	assign elim_next  = (row_q + 1'b1 == col_k) ? row_q + 2'd2 : row_q + 1'b1;   // skip pivot row
	assign elim_last  = elim_next >= row_idx_t'(MAT_N);

	//////////////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= IDLE;
			col_k    <= '0;
			row_q    <= '0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (start)
					begin
						col_k    <= '0;
						singular <= 1'b0;
						state    <= SEARCH;
					end
				SEARCH:
					if (!found)
					begin
						singular <= 1'b1;
						state    <= FINISH;
					end
					else if (piv_sel != col_k)
					begin
						row_q <= piv_sel;
						state <= SWAP;
					end
					else
					begin
						row_q <= first_elim;
						state <= ELIM;
					end
				SWAP:
				begin
					row_q <= first_elim;
					state <= ELIM;
				end
				ELIM:
					if (!elim_last)
						row_q <= elim_next;
					else if (col_k == row_idx_t'(MAT_N - 1))
					begin
						row_q <= '0;
						state <= NORM;
					end
					else
					begin
						col_k <= col_k + 1'b1;
						state <= SEARCH;
					end
				NORM:
					if (row_q == row_idx_t'(MAT_N - 1))
						state <= FINISH;
					else
						row_q <= row_q + 1'b1;
				default:
					state <= IDLE;   // FINISH
			endcase
		end
	end

	always_comb
	begin
		cmd.op  = OP_NONE;
		cmd.col = col_k;
		cmd.piv = col_k;
		cmd.tgt = row_q;
		case (state)
			SWAP: cmd.op = OP_SWAP;
			ELIM: cmd.op = OP_ELIM;
			NORM:
			begin
				cmd.op  = OP_NORM;   // each row divided by its own diagonal
				cmd.col = row_q;
				cmd.piv = row_q;
			end
			default: ;
		endcase
	end

	assign busy = (state != IDLE);
	assign done = (state == FINISH);

endmodule

`default_nettype wire

// ==== src/mat_pkg.sv ====
`default_nettype none

package mat_pkg;

	localparam int MAT_N     = 5;
	localparam int AUG_N     = 2 * MAT_N;
	localparam int FIX_W     = 32;
	localparam int FRAC_BITS = 16;

	typedef logic signed [FIX_W-1:0] fix_t;   // signed 16.16
	typedef logic [2:0] row_idx_t;

	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);

	typedef fix_t [MAT_N-1:0] mat_row_t;      // element 0 is column 0
	typedef fix_t [AUG_N-1:0] aug_row_t;      // left half matrix, right half inverse

	typedef enum logic [1:0] {
		OP_NONE,
		OP_SWAP,
		OP_ELIM,
		OP_NORM
	} row_op_t;

	typedef struct packed {
		row_op_t  op;
		row_idx_t col;   // pivot column
		row_idx_t piv;   // pivot row
		row_idx_t tgt;   // row being written
	} row_cmd_t;

endpackage

`default_nettype wire

// ==== src/matrix_inverse.sv ====
`default_nettype none

module matrix_inverse (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  logic              start,
	input  mat_pkg::mat_row_t load_row,
	input  mat_pkg::row_idx_t rd_idx,
	output mat_pkg::mat_row_t rd_row,
	output logic              busy,
	output logic              done,
	output logic              singular
);
	import mat_pkg::*;

	row_cmd_t cmd;
	aug_row_t piv_row;
	aug_row_t tgt_row;
	aug_row_t new_row;
	mat_row_t col_elems;

	//////////////////////////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////////////////////////

	matrix_store u_store (
		.clk       (clk),
		.rst       (rst),
		.load      (load),
		.load_row  (load_row),
		.cmd       (cmd),
		.new_row   (new_row),
		.piv_row   (piv_row),
		.tgt_row   (tgt_row),
		.col_elems (col_elems),
		.rd_idx    (rd_idx),
		.rd_row    (rd_row)
	);

	row_alu u_alu (
		.cmd     (cmd),
		.piv_row (piv_row),
		.tgt_row (tgt_row),
		.new_row (new_row)   // written back on the next edge
	);

	// control
	inverse_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.col_elems (col_elems),
		.cmd       (cmd),
		.busy      (busy),
		.done      (done),
		.singular  (singular)
	);

endmodule

`default_nettype wire

// ==== src/matrix_store.sv ====
`default_nettype none

module matrix_store (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  mat_pkg::mat_row_t load_row,
	input  mat_pkg::row_cmd_t cmd,
	input  mat_pkg::aug_row_t new_row,
	output mat_pkg::aug_row_t piv_row,
	output mat_pkg::aug_row_t tgt_row,
	output mat_pkg::mat_row_t col_elems,
	input  mat_pkg::row_idx_t rd_idx,
	output mat_pkg::mat_row_t rd_row
);
	import mat_pkg::*;

	aug_row_t mat [MAT_N];
	row_idx_t ld_ptr;
	aug_row_t load_aug;

	// incoming row with its identity row on the right
	always_comb
	begin
		for (int j = 0; j < MAT_N; j++)
		begin
			load_aug[j]         = load_row[j];
			load_aug[MAT_N + j] = (row_idx_t'(j) == ld_ptr) ? FIX_ONE : '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// row writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (cmd.op)
			OP_SWAP:
			begin
				mat[cmd.piv] <= tgt_row;
				mat[cmd.tgt] <= piv_row;
			end
			OP_ELIM, OP_NORM:
				mat[cmd.tgt] <= new_row;
			default:
				if (load)
					mat[ld_ptr] <= load_aug;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			ld_ptr <= '0;
		else if (load && cmd.op == OP_NONE)
			ld_ptr <= (ld_ptr == row_idx_t'(MAT_N - 1)) ? '0 : ld_ptr + 1'b1;   // wrap after last row
	end

	assign piv_row = mat[cmd.piv];
	assign tgt_row = mat[cmd.tgt];
	assign rd_row  = mat[rd_idx][AUG_N-1:MAT_N];

	// pivot column of every row, for the search
	always_comb
	begin
		for (int i = 0; i < MAT_N; i++)
			col_elems[i] = mat[i][cmd.col];
	end

endmodule

`default_nettype wire

// ==== src/row_alu.sv ====
`default_nettype none

module row_alu (
	input  mat_pkg::row_cmd_t cmd,
	input  mat_pkg::aug_row_t piv_row,
	input  mat_pkg::aug_row_t tgt_row,
	output mat_pkg::aug_row_t new_row
);
	import mat_pkg::*;

	always_comb
	begin
		fix_t pk;
		fix_t rk;
		fix_t pj;
		fix_t rj;
		logic signed [63:0] num;
		logic signed [63:0] quot;
		logic signed [95:0] prod;

		pk = piv_row[cmd.col];
		rk = tgt_row[cmd.col];
		if (pk == '0)
			pk = fix_t'(1);   // rows may hold zeros outside elim/norm
		if (rk == '0)
			rk = fix_t'(1);
		for (int j = 0; j < AUG_N; j++)
		begin
			pj   = piv_row[j];
			rj   = tgt_row[j];
			num  = '0;
			quot = '0;
			prod = '0;
			case (cmd.op)
				OP_ELIM:
				begin
					num  = 64'(pj) <<< FRAC_BITS;
					quot = num / 64'(pk);                        // p[j]/p[k], truncated
					prod = (96'(quot) * 96'(tgt_row[cmd.col])) / (96'sd1 <<< FRAC_BITS);
					new_row[j] = rj - fix_t'(prod);
				end
				OP_NORM:
				begin
					num  = 64'(rj) <<< FRAC_BITS;
					quot = num / 64'(rk);
					new_row[j] = fix_t'(quot);
				end
				default:
					new_row[j] = rj;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb/matrix_inverse_props.sv ====
`default_nettype none

module matrix_inverse_props (
	input logic clk,
	input logic rst,
	input logic load,
	input logic start,
	input logic busy,
	input logic done,
	input logic singular
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////////////////////////
	// control output rules
	//////////////////////////////////////////////////////////////////////

	// one cycle only
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done held high for more than one cycle");

	a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
		else $error("done without busy in the previous cycle");

	// rows only taken while idle
	a_load_idle: assert property (@(posedge clk) disable iff (rst) load |-> !busy)
		else $error("load strobe while busy");

	// singular moves only on start or during a run
	a_sing_level: assert property (@(posedge clk) disable iff (rst)
		(singular != $past(singular)) |-> ($past(busy) || $past(start)))
		else $error("singular changed while idle");

endmodule

bind matrix_inverse matrix_inverse_props u_props (
	.clk      (clk),
	.rst      (rst),
	.load     (load),
	.start    (start),
	.busy     (busy),
	.done     (done),
	.singular (singular)
);

`default_nettype wire

// ==== tb/tb_matrix_inverse.sv ====
`default_nettype none

module tb_matrix_inverse;
	timeunit 1ns;
	timeprecision 1ps;

	import mat_pkg::*;

	typedef struct packed {
		mat_row_t [MAT_N-1:0] a;      // rows loaded into the DUT
		logic                 sing;   // expected singular flag
		mat_row_t [MAT_N-1:0] inv;    // expected inverse rows
	} vec_t;

	localparam int NUM_VEC = 6;
	localparam int MAX_RUN = 36;   // longest start-to-done run
	localparam int TIMEOUT = NUM_VEC * (MAT_N + MAX_RUN + 10) + 100;

	logic     clk;
	logic     rst;
	logic     load;
	logic     start;
	mat_row_t load_row;
	row_idx_t rd_idx;
	mat_row_t rd_row;
	logic     busy;
	logic     done;
	logic     singular;

	vec_t table_q [NUM_VEC];
	int   cycles;

	matrix_inverse dut (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.start    (start),
		.load_row (load_row),
		.rd_idx   (rd_idx),
		.rd_row   (rd_row),
		.busy     (busy),
		.done     (done),
		.singular (singular)
	);

	//////////////////////////////////////////////////////////////////////
	// clock and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
		$display("Simulation failed");
		$fatal(1);
	end

	//////////////////////////////////////////////////////////////////////
	// value helpers
	//////////////////////////////////////////////////////////////////////

	// num/den in 16.16, exact for the ratios used here
	function automatic fix_t to_fix(input int num, input int den);
		longint scaled;
		scaled = longint'(num) <<< FRAC_BITS;
		return fix_t'(scaled / den);
	endfunction

	function automatic mat_row_t unit_row(input int c);
		mat_row_t r;
		r    = '0;
		r[c] = FIX_ONE;
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table;
		fix_t     diag [MAT_N];
		fix_t     recip [MAT_N];
		mat_row_t dup;

		diag[0]  = to_fix(2, 1);
		diag[1]  = to_fix(4, 1);
		diag[2]  = to_fix(1, 2);
		diag[3]  = to_fix(8, 1);
		diag[4]  = to_fix(1, 1);
		recip[0] = to_fix(1, 2);
		recip[1] = to_fix(1, 4);
		recip[2] = to_fix(2, 1);
		recip[3] = to_fix(1, 8);
		recip[4] = to_fix(1, 1);

		dup    = '0;
		dup[0] = to_fix(1, 1);
		dup[1] = to_fix(2, 1);

		for (int i = 0; i < MAT_N; i++)
		begin
			// identity
			table_q[0].a[i]   = unit_row(i);
			table_q[0].inv[i] = unit_row(i);

			// diagonal, reciprocals expected
			table_q[1].a[i]      = '0;
			table_q[1].a[i][i]   = diag[i];
			table_q[1].inv[i]    = '0;
			table_q[1].inv[i][i] = recip[i];

			// cyclic permutation, zero at (0,0), inverse is the transpose
			table_q[2].a[i]   = unit_row((i + 1) % MAT_N);
			table_q[2].inv[i] = unit_row((i + MAT_N - 1) % MAT_N);

			// ones on diagonal, -1 above it
			table_q[3].a[i]    = unit_row(i);
			if (i < MAT_N - 1)
				table_q[3].a[i][i + 1] = to_fix(-1, 1);
			table_q[3].inv[i] = '0;
			for (int j = i; j < MAT_N; j++)
				table_q[3].inv[i][j] = to_fix(1, 1);   // upper triangle of ones

			// rows 0 and 1 equal
			table_q[4].a[i]   = (i < 2) ? dup : unit_row(i);
			table_q[4].inv[i] = '0;

			table_q[5].a[i]   = unit_row(i);
			table_q[5].inv[i] = unit_row(i);
		end

		table_q[0].sing = 1'b0;
		table_q[1].sing = 1'b0;
		table_q[2].sing = 1'b0;
		table_q[3].sing = 1'b0;
		table_q[4].sing = 1'b1;
		table_q[5].sing = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_row(input string name, input mat_row_t got, input mat_row_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus tasks, all entered on a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic load_matrix(input vec_t v);
		for (int i = 0; i < MAT_N; i++)
		begin
			load     = 1'b1;
			load_row = v.a[i];
			@(negedge clk);
		end
		load     = 1'b0;
		load_row = '0;
	endtask

	task automatic run_inversion;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_bit("busy", busy, 1'b1);
		check_bit("singular", singular, 1'b0);   // cleared by start
		while (done !== 1'b1)
			@(negedge clk);
	endtask

	task automatic check_result(input vec_t v);
		string name;

		check_bit("singular", singular, v.sing);
		@(negedge clk);
		check_bit("done", done, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("singular", singular, v.sing);   // level holds after done
		if (!v.sing)
		begin
			for (int r = 0; r < MAT_N; r++)
			begin
				rd_idx = row_idx_t'(r);
				@(negedge clk);
				name = $sformatf("rd_row[%0d]", r);
				check_row(name, rd_row, v.inv[r]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst      = 1'b1;
		load     = 1'b0;
		start    = 1'b0;
		load_row = '0;
		rd_idx   = '0;
		build_table();

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		for (int e = 0; e < NUM_VEC; e++)
		begin
			load_matrix(table_q[e]);
			run_inversion();
			check_result(table_q[e]);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
